// File: flist.f
source/sram_domain_pkg.sv
source/bank_addr_decode.sv
source/sram_bank.sv
source/bank_rsp_mux.sv
source/sram_domain.sv
testbench/sram_domain_asserts.sv
testbench/tb_sram_domain.sv

// File: source/bank_addr_decode.sv
module bank_addr_decode import sram_domain_pkg::*; (
  input  bus_req_t                 bus_req_i,
  output bank_req_t [NumBanks-1:0] bank_req_o,
  output logic                     err_hit_o
);

  logic       in_range;
  bank_idx_t  bank_idx;
  word_addr_t word_addr;

  // --------------------------------------------------------------------------
  // Range check
  // --------------------------------------------------------------------------
  // Upper bound excluded
  assign in_range = (bus_req_i.addr >= MemBaseAddr) &&
                    (bus_req_i.addr < (MemBaseAddr + addr_t'(MemSizeBytes)));

  // Everything outside the memory goes to the error subordinate
  assign err_hit_o = bus_req_i.req && !in_range;

  // --------------------------------------------------------------------------
  // Field extraction
  // --------------------------------------------------------------------------
  // Base is size aligned, so the fields come straight from the address
  assign word_addr = bus_req_i.addr[ByteOffWidth +: WordAddrWidth];
  assign bank_idx  = bus_req_i.addr[ByteOffWidth + WordAddrWidth +: BankIdxWidth];

  // --------------------------------------------------------------------------
  // Bank request fan-out
  // --------------------------------------------------------------------------
  always_comb begin
    for (int unsigned i = 0; i < NumBanks; i++) begin
      // One-hot req, payload shared by all banks
      bank_req_o[i].req       = bus_req_i.req && in_range &&
                                (bank_idx == bank_idx_t'(i));
      bank_req_o[i].we        = bus_req_i.we;
      bank_req_o[i].be        = bus_req_i.be;
      bank_req_o[i].word_addr = word_addr;
      bank_req_o[i].wdata     = bus_req_i.wdata;
    end
  end

endmodule

// File: source/bank_rsp_mux.sv
module bank_rsp_mux import sram_domain_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  bank_req_t [NumBanks-1:0] bank_req_i,
  input  logic                     err_hit_i,
  input  data_t     [NumBanks-1:0] bank_rdata_i,
  output bus_rsp_t                 bus_rsp_o
);

  // Request side
  logic      bank_hit;
  logic      hit_we;
  bank_idx_t hit_idx;
  logic      accept;

  // Response side
  logic      rvalid_q;
  logic      we_q;
  logic      err_q;
  bank_idx_t sel_q;

  // --------------------------------------------------------------------------
  // Find the addressed bank
  // --------------------------------------------------------------------------
  always_comb begin
    bank_hit = 1'b0;
    hit_we   = 1'b0;
    hit_idx  = '0;
    for (int unsigned i = 0; i < NumBanks; i++) begin
      if (bank_req_i[i].req) begin
        bank_hit = 1'b1;
        hit_we   = bank_req_i[i].we;
        hit_idx  = bank_idx_t'(i);
      end
    end
  end

  // Banks and error subordinate always accept
  assign accept = bank_hit | err_hit_i;

  // --------------------------------------------------------------------------
  // Outstanding response
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      we_q     <= 1'b0;
      err_q    <= 1'b0;
      sel_q    <= '0;
    end else begin
      rvalid_q <= accept;
      if (accept) begin
        we_q  <= hit_we;
        err_q <= err_hit_i;
        sel_q <= hit_idx;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Bus response
  // --------------------------------------------------------------------------
  always_comb begin
    bus_rsp_o.gnt    = accept;
    bus_rsp_o.rvalid = rvalid_q;
    bus_rsp_o.err    = err_q;
    // Error data wins over write zero
    if (err_q) begin
      bus_rsp_o.rdata = ErrRspData;
    end else if (we_q) begin
      bus_rsp_o.rdata = '0;
    end else begin
      bus_rsp_o.rdata = bank_rdata_i[sel_q];
    end
  end

endmodule

// File: source/sram_bank.sv
module sram_bank import sram_domain_pkg::*; (
  input  logic      clk_i,
  input  bank_req_t bank_req_i,
  output data_t     rdata_o
);

  // Storage array, contents undefined after power-up
  data_t mem_q [BankNumWords];

  // --------------------------------------------------------------------------
  // Single port access
  // --------------------------------------------------------------------------
  // Write lands at the edge, read data appears one cycle later
  always_ff @(posedge clk_i) begin
    if (bank_req_i.req) begin
      if (bank_req_i.we) begin
        for (int unsigned b = 0; b < BeWidth; b++) begin
          // Only enabled byte lanes
          if (bank_req_i.be[b]) begin
            mem_q[bank_req_i.word_addr][8*b +: 8] <= bank_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[bank_req_i.word_addr];
      end
    end
  end

endmodule

// File: source/sram_domain.sv
module sram_domain import sram_domain_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o
);

  // --------------------------------------------------------------------------
  // Internal nets
  // --------------------------------------------------------------------------
  bank_req_t [NumBanks-1:0] bank_req;
  data_t     [NumBanks-1:0] bank_rdata;
  logic                     err_hit;

  // --------------------------------------------------------------------------
  // Address decode
  // --------------------------------------------------------------------------
  bank_addr_decode i_addr_decode (
    .bus_req_i  ( bus_req_i ),
    .bank_req_o ( bank_req  ),
    .err_hit_o  ( err_hit   )
  );

  // --------------------------------------------------------------------------
  // Memory banks
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    sram_bank i_sram_bank (
      .clk_i,
      .bank_req_i ( bank_req[i]   ),
      .rdata_o    ( bank_rdata[i] )
    );
  end

  // --------------------------------------------------------------------------
  // Response path
  // --------------------------------------------------------------------------
  // Decoder raises exactly one of bank req or err_hit, so gnt tracks req
  bank_rsp_mux i_rsp_mux (
    .clk_i,
    .rst_n_i,
    .bank_req_i   ( bank_req   ),
    .err_hit_i    ( err_hit    ),
    .bank_rdata_i ( bank_rdata ),
    .bus_rsp_o    ( bus_rsp_o  )
  );

endmodule

// File: source/sram_domain_pkg.sv
package sram_domain_pkg;

  // --------------------------------------------------------------------------
  // Widths and memory organisation
  // --------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Identical word-wide banks
  localparam int unsigned NumBanks     = 4;
  localparam int unsigned BankNumWords = 256;

  // Widths of the address fields
  localparam int unsigned ByteOffWidth  = $clog2(BeWidth);
  localparam int unsigned WordAddrWidth = $clog2(BankNumWords);
  localparam int unsigned BankIdxWidth  = $clog2(NumBanks);

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------
  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [BeWidth-1:0]       be_t;
  typedef logic [BankIdxWidth-1:0]  bank_idx_t;
  typedef logic [WordAddrWidth-1:0] word_addr_t;

  // --------------------------------------------------------------------------
  // Address map
  // --------------------------------------------------------------------------
  // Base is aligned to the memory size
  localparam addr_t       MemBaseAddr  = 32'h1000_0000;
  localparam int unsigned MemSizeBytes = NumBanks * BankNumWords * BeWidth;

  // Read data of the error subordinate
  localparam data_t ErrRspData = 32'hBADCAB1E;

  // --------------------------------------------------------------------------
  // Bus structs
  // --------------------------------------------------------------------------
  // Manager request
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Subordinate response, rdata and err qualified by rvalid
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Request as seen by a single bank
  typedef struct packed {
    logic       req;
    logic       we;
    be_t        be;
    word_addr_t word_addr;
    data_t      wdata;
  } bank_req_t;

endpackage

// File: testbench/sram_domain_asserts.sv
module sram_domain_asserts import sram_domain_pkg::*; (
  input logic     clk_i,
  input logic     rst_n_i,
  input bus_req_t bus_req_i,
  input bus_rsp_t bus_rsp_o
);

  logic accepted;

  assign accepted = bus_req_i.req && bus_rsp_o.gnt;

  // --------------------------------------------------------------------------
  // Handshake
  // --------------------------------------------------------------------------
  // No back-pressure
  gnt_follows_req: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) bus_rsp_o.gnt == bus_req_i.req
  ) else $error("gnt differs from req");

  rvalid_after_accept: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) accepted |=> bus_rsp_o.rvalid
  ) else $error("accepted request got no rvalid in the next cycle");

  // Every rvalid belongs to a request
  rvalid_only_after_accept: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !accepted |=> !bus_rsp_o.rvalid
  ) else $error("rvalid without an accepted request");

  // --------------------------------------------------------------------------
  // Reset
  // --------------------------------------------------------------------------
  rvalid_low_in_reset: assert property (
    @(posedge clk_i) !rst_n_i |-> !bus_rsp_o.rvalid
  ) else $error("rvalid high during reset");

endmodule

bind sram_domain sram_domain_asserts u_asserts (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .bus_req_i ( bus_req_i ),
  .bus_rsp_o ( bus_rsp_o )
);

// File: testbench/tb_sram_domain.sv
module tb_sram_domain import sram_domain_pkg::*; ();

  localparam int unsigned ClkPeriod    = 4;
  localparam int unsigned ResetCycles  = 10;
  localparam int unsigned MarginCycles = 50;
  localparam int unsigned BankBytes    = BankNumWords * 4;

  // One table row holds a request and the response it must produce
  typedef struct packed {
    logic  we;
    addr_t addr;
    be_t   be;
    data_t wdata;
    data_t exp_rdata;
    logic  exp_err;
  } stim_t;

  logic     clk_i;
  logic     rst_n_i;
  bus_req_t bus_req_i;
  bus_rsp_t bus_rsp_o;

  stim_t table_q [$];
  stim_t exp_q [$];
  data_t ref_mem [addr_t];
  data_t rng_state;
  logic  req_pending;
  bit    table_ready;

  sram_domain dut0 (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .bus_req_i ( bus_req_i ),
    .bus_rsp_o ( bus_rsp_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Stimulus generation and reference model
  // --------------------------------------------------------------------------
  function automatic data_t next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic addr_t word_address(input int unsigned bank, input int unsigned word);
    return MemBaseAddr + addr_t'(bank * BankBytes + word * 4);
  endfunction

  // Offset from the base wraps around for addresses below it
  function automatic logic in_memory(input addr_t addr);
    addr_t offset;
    offset = addr - MemBaseAddr;
    return offset < addr_t'(MemSizeBytes);
  endfunction

  // Appends one access and works out its response from the model
  function automatic void push_access(input logic we, input addr_t addr, input be_t be,
                                      input data_t wdata);
    stim_t s;
    addr_t key;
    data_t merged;
    s = '{we: we, addr: addr, be: be, wdata: wdata, exp_rdata: '0, exp_err: 1'b0};
    key = {addr[31:2], 2'b00};
    if (!in_memory(addr)) begin
      s.exp_rdata = ErrRspData;
      s.exp_err   = 1'b1;
    end else if (we) begin
      merged = ref_mem.exists(key) ? ref_mem[key] : '0;
      for (int b = 0; b < 4; b++) begin
        if (be[b]) merged[8*b +: 8] = wdata[8*b +: 8];
      end
      ref_mem[key] = merged;
    end else if (ref_mem.exists(key)) begin
      s.exp_rdata = ref_mem[key];
    end else begin
      $display("stimulus table reads address %h before any write to it", addr);
      $display("Simulation finished: FAIL");
      $fatal(1, "bad stimulus table");
    end
    table_q.push_back(s);
  endfunction

  function automatic void build_table();
    int unsigned offs [3] = '{0, 5, 255};
    addr_t       a;
    // Full words in every bank written and read back
    for (int b = 0; b < NumBanks; b++) begin
      foreach (offs[k]) begin
        a = word_address(b, offs[k]);
        push_access(1'b1, a, 4'hf, next_random());
        push_access(1'b0, a, 4'h0, '0);
      end
    end
    // Same offset in all banks
    for (int b = 0; b < NumBanks; b++) push_access(1'b1, word_address(b, 8'h40), 4'hf,
                                                    next_random());
    for (int b = 0; b < NumBanks; b++) push_access(1'b0, word_address(b, 8'h40), 4'h0, '0);
    // Byte enables
    a = word_address(2, 8'h80);
    push_access(1'b1, a, 4'hf, next_random());
    push_access(1'b1, a, 4'b0101, next_random());
    push_access(1'b0, a, 4'h0, '0);
    push_access(1'b1, a, 4'b1000, next_random());
    push_access(1'b0, a, 4'h0, '0);
    // Outside the memory and then the aliased in-range word
    a = MemBaseAddr + addr_t'(MemSizeBytes) + addr_t'(8'h40 * 4);
    push_access(1'b0, a, 4'h0, '0);
    push_access(1'b1, a, 4'hf, next_random());
    push_access(1'b0, MemBaseAddr - 4, 4'h0, '0);
    push_access(1'b1, 32'h0000_0000, 4'hf, next_random());
    push_access(1'b0, word_address(0, 8'h40), 4'h0, '0);
    push_access(1'b0, MemBaseAddr + addr_t'(MemSizeBytes) - 4, 4'h0, '0);
    // Burst over the banks and read back in reverse
    for (int i = 0; i < 8; i++) push_access(1'b1, word_address(i % 4, 8'hc0 + i), 4'hf,
                                             next_random());
    for (int i = 7; i >= 0; i--) push_access(1'b0, word_address(i % 4, 8'hc0 + i), 4'h0, '0);
  endfunction

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "bit mismatch");
    end
  endtask

  // Checks the response to the previous cycle and the gnt of the current one
  task automatic check_cycle();
    stim_t s;
    check_bit("gnt", bus_req_i.req, bus_rsp_o.gnt);
    check_bit("rvalid", req_pending, bus_rsp_o.rvalid);
    if (bus_rsp_o.rvalid) begin
      s = exp_q.pop_front();
      check_data("rdata", s.exp_rdata, bus_rsp_o.rdata);
      check_bit("err", s.exp_err, bus_rsp_o.err);
    end
  endtask

  task automatic drive_request(input stim_t s);
    bus_req_i.req   = 1'b1;
    bus_req_i.we    = s.we;
    bus_req_i.be    = s.be;
    bus_req_i.addr  = s.addr;
    bus_req_i.wdata = s.wdata;
    exp_q.push_back(s);
    req_pending = 1'b1;
  endtask

  task automatic drive_idle();
    bus_req_i   = '0;
    req_pending = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin : stimulus
    rst_n_i     = 1'b0;
    bus_req_i   = '0;
    req_pending = 1'b0;
    rng_state   = 32'ha324;
    build_table();
    table_ready = 1'b1;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // Quiet bus right after reset
    repeat (3) begin
      @(negedge clk_i);
      check_cycle();
    end
    foreach (table_q[i]) begin
      @(negedge clk_i);
      check_cycle();
      drive_request(table_q[i]);
    end
    repeat (2) begin
      @(negedge clk_i);
      check_cycle();
      drive_idle();
    end
    if (exp_q.size() != 0) begin
      $display("%0d responses never arrived", exp_q.size());
      $display("Simulation finished: FAIL");
      $fatal(1, "missing responses");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  initial begin : watchdog
    wait (table_ready);
    repeat (ResetCycles + table_q.size() * 4 + MarginCycles) @(posedge clk_i);
    $display("run timed out without finishing");
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

endmodule
